/* src/fifo_cfg.svh */
// width converting fifo configuration
`ifndef FIFO_CFG_SVH
`define FIFO_CFG_SVH

// capacity counted in 64-bit qwords
`define FIFO_QWORD_DEPTH 32

// distance from either end that raises the almost flags
`define FIFO_ALMOST_MARGIN 10

// extra cycles after each gray crossing before a delta is applied
`define FIFO_XING_DELAY 3

// counters wrap at twice the depth
`define FIFO_CNT_WIDTH 6

// data and address widths
`define FIFO_OWORD_WIDTH 128
`define FIFO_QWORD_WIDTH 64
`define FIFO_OADDR_WIDTH 4
`define FIFO_QADDR_WIDTH 5

`endif

/* src/fifo_pkg.sv */
// width converting fifo types
`include "fifo_cfg.svh"

package fifo_pkg;

	// 128-bit word on the write side
	typedef logic [`FIFO_OWORD_WIDTH-1:0] oword_t;

	// 64-bit word on the read side
	typedef logic [`FIFO_QWORD_WIDTH-1:0] qword_t;

	// fill level or counter, in qwords
	typedef logic [`FIFO_CNT_WIDTH-1:0] qcount_t;

	// oword slot in the storage array
	typedef logic [`FIFO_OADDR_WIDTH-1:0] oaddr_t;

	// qword index: slot in the upper bits, half in bit 0
	typedef logic [`FIFO_QADDR_WIDTH-1:0] qaddr_t;

endpackage

/* src/fifo_ptr_if.sv */
// fifo memory access
`timescale 1ns/100ps

interface fifo_ptr_if;
	import fifo_pkg::*;

	// write access, wrclk domain
	logic wr_fire;
	oaddr_t wr_addr;

	// read access, read clock domain
	logic rd_fire;
	qaddr_t rd_addr;

	// counter side drives every strobe and address
	modport calc (
		output wr_fire, wr_addr, rd_fire, rd_addr
	);

	// storage only follows the strobes
	modport ram (
		input wr_fire, wr_addr, rd_fire, rd_addr
	);

endinterface

/* src/gray_sync.sv */
// gray code counter synchronizer
`timescale 1ns/100ps
`include "fifo_cfg.svh"

module gray_sync (
	input logic in_clk,
	input logic out_clk,
	input logic rdclock,
	input fifo_pkg::qcount_t data,
	output fifo_pkg::qcount_t q
);
	import fifo_pkg::*;

	// gray copy held in the source domain
	qcount_t gray_src;
	// two stage synchronizer in the destination domain
	qcount_t gray_meta;
	qcount_t gray_sync_q;

	// binary to gray in a register so no glitch reaches the crossing
	always_ff @(posedge in_clk or posedge rdclock) begin
		if (rdclock) begin
			gray_src <= '0;
		end else begin
			gray_src <= data ^ (data >> 1);
		end
	end

	// a counter step flips one gray bit, so the far side sees old or new
	always_ff @(posedge out_clk or posedge rdclock) begin
		if (rdclock) begin
			gray_meta <= '0;
			gray_sync_q <= '0;
		end else begin
			gray_meta <= gray_src;
			gray_sync_q <= gray_meta;
		end
	end

	// gray back to binary from the msb down
	always_comb begin
		q[`FIFO_CNT_WIDTH-1] = gray_sync_q[`FIFO_CNT_WIDTH-1];
		for (int i = `FIFO_CNT_WIDTH - 2; i >= 0; i--) begin
			q[i] = q[i+1] ^ gray_sync_q[i];
		end
	end

endmodule

/* src/delay_line.sv */
// count delay chain
`timescale 1ns/100ps

module delay_line #(
	parameter int DELAY = 1
) (
	input logic clk,
	input logic rdclock,
	input fifo_pkg::qcount_t data,
	output fifo_pkg::qcount_t q
);
	import fifo_pkg::*;

	generate
		if (DELAY == 0) begin : g_none
			// no extra stages requested
			assign q = data;
		end else begin : g_chain
			// every stage holds one delta, so back to back changes survive
			qcount_t stages [DELAY];

			always_ff @(posedge clk or posedge rdclock) begin
				if (rdclock) begin
					for (int i = 0; i < DELAY; i++) begin
						stages[i] <= '0;
					end
				end else begin
					stages[0] <= data;
					for (int i = 1; i < DELAY; i++) begin
						stages[i] <= stages[i-1];
					end
				end
			end

			assign q = stages[DELAY-1];
		end
	endgenerate

endmodule

/* src/usedw_calc.sv */
// dual clock fill level calculator
`timescale 1ns/100ps
`include "fifo_cfg.svh"

module usedw_calc (
	input logic wrclk,
	input logic reset,
	input logic rdclock,
	input logic wr_req,
	input logic rd_req,
	fifo_ptr_if.calc ptr,
	output fifo_pkg::qcount_t wr_used,
	output fifo_pkg::qcount_t rd_used,
	output logic full,
	output logic almost_full,
	output logic empty,
	output logic almost_empty
);
	import fifo_pkg::*;

	// each write is one oword, two qwords; each read is one qword
	localparam qcount_t WR_STEP = qcount_t'(2);
	localparam qcount_t RD_STEP = qcount_t'(1);
	localparam qcount_t FULL_LEVEL = qcount_t'(`FIFO_QWORD_DEPTH);
	localparam qcount_t AF_LEVEL = qcount_t'(`FIFO_QWORD_DEPTH - `FIFO_ALMOST_MARGIN);
	localparam qcount_t AE_LEVEL = qcount_t'(`FIFO_ALMOST_MARGIN);

	// free running access counters
	qcount_t wr_cnt, rd_cnt;
	// write counter in owords, bit 0 of wr_cnt is always zero
	qcount_t wr_ocnt, wr_ocnt_xing;
	// counters as seen in the opposite domain
	qcount_t wr_xing, wr_xing_prev, rd_xing, rd_xing_prev;
	// per cycle change seen on the far side, before and after delay
	qcount_t wr_delta, wr_delta_dly, rd_delta, rd_delta_dly;
	// next fill levels
	qcount_t wr_base, wr_next, rd_base, rd_next;

	// ----------------------------------------------------------
	// access counters and memory strobes
	// ----------------------------------------------------------
	always_ff @(posedge wrclk or posedge rdclock) begin
		if (rdclock) begin
			wr_cnt <= '0;
		end else if (wr_req) begin
			wr_cnt <= wr_cnt + WR_STEP;
		end
	end

	always_ff @(posedge reset or posedge rdclock) begin
		if (rdclock) begin
			rd_cnt <= '0;
		end else if (rd_req) begin
			rd_cnt <= rd_cnt + RD_STEP;
		end
	end

	// slot comes from the oword part of the write counter
	assign ptr.wr_fire = wr_req;
	assign ptr.wr_addr = wr_cnt[`FIFO_CNT_WIDTH-2:1];
	// low half first since the read counter starts even
	assign ptr.rd_fire = rd_req;
	assign ptr.rd_addr = rd_cnt[`FIFO_CNT_WIDTH-2:0];

	// ----------------------------------------------------------
	// crossings
	// ----------------------------------------------------------
	// a step of two would flip two gray bits, so cross the oword count
	assign wr_ocnt = {1'b0, wr_cnt[`FIFO_CNT_WIDTH-1:1]};

	gray_sync u_wr_sync (
		.in_clk(wrclk),
		.out_clk(reset),
		.rdclock(rdclock),
		.data(wr_ocnt),
		.q(wr_ocnt_xing)
	);

	// back to qwords on the read side
	assign wr_xing = {wr_ocnt_xing[`FIFO_CNT_WIDTH-2:0], 1'b0};

	gray_sync u_rd_sync (
		.in_clk(reset),
		.out_clk(wrclk),
		.rdclock(rdclock),
		.data(rd_cnt),
		.q(rd_xing)
	);

	// remember last crossed values to form deltas
	always_ff @(posedge reset or posedge rdclock) begin
		if (rdclock) begin
			wr_xing_prev <= '0;
		end else begin
			wr_xing_prev <= wr_xing;
		end
	end

	always_ff @(posedge wrclk or posedge rdclock) begin
		if (rdclock) begin
			rd_xing_prev <= '0;
		end else begin
			rd_xing_prev <= rd_xing;
		end
	end

	// modulo difference handles counter wrap
	assign wr_delta = wr_xing - wr_xing_prev;
	assign rd_delta = rd_xing - rd_xing_prev;

	delay_line #(.DELAY(`FIFO_XING_DELAY)) u_wr_delay (
		.clk(reset),
		.rdclock(rdclock),
		.data(wr_delta),
		.q(wr_delta_dly)
	);

	delay_line #(.DELAY(`FIFO_XING_DELAY)) u_rd_delay (
		.clk(wrclk),
		.rdclock(rdclock),
		.data(rd_delta),
		.q(rd_delta_dly)
	);

	// ----------------------------------------------------------
	// fill levels and flags
	// ----------------------------------------------------------
	// write side: own writes now, remote reads late; clamp at zero
	always_comb begin
		wr_base = wr_used + (wr_req ? WR_STEP : '0);
		wr_next = (rd_delta_dly > wr_base) ? '0 : wr_base - rd_delta_dly;
	end

	// read side: remote writes late, own reads now; clamp at zero
	always_comb begin
		rd_base = rd_used + wr_delta_dly;
		rd_next = (rd_req && rd_base != '0) ? rd_base - RD_STEP : rd_base;
	end

	// flags follow the registered count by one cycle
	always_ff @(posedge wrclk or posedge rdclock) begin
		if (rdclock) begin
			wr_used <= '0;
			full <= 1'b0;
			almost_full <= 1'b0;
		end else begin
			wr_used <= wr_next;
			full <= (wr_used == FULL_LEVEL);
			almost_full <= (wr_used >= AF_LEVEL);
		end
	end

	// starts empty
	always_ff @(posedge reset or posedge rdclock) begin
		if (rdclock) begin
			rd_used <= '0;
			empty <= 1'b1;
			almost_empty <= 1'b1;
		end else begin
			rd_used <= rd_next;
			empty <= (rd_used == '0);
			almost_empty <= (rd_used <= AE_LEVEL);
		end
	end

endmodule

/* src/fifo_ram.sv */
// oword storage with qword read port
`timescale 1ns/100ps
`include "fifo_cfg.svh"

module fifo_ram (
	input logic wrclk,
	input logic reset,
	input logic rdclock,
	fifo_ptr_if.ram ptr,
	input fifo_pkg::oword_t wr_data,
	output fifo_pkg::qword_t rd_data,
	output logic rd_valid
);
	import fifo_pkg::*;

	// two qwords per slot
	localparam int SLOTS = `FIFO_QWORD_DEPTH / 2;

	oword_t mem [SLOTS];

	// read path decode
	oaddr_t rd_slot;
	qword_t rd_word;

	// ----------------------------------------------------------
	// write port, wrclk
	// ----------------------------------------------------------
	always_ff @(posedge wrclk) begin
		if (ptr.wr_fire) begin
			mem[ptr.wr_addr] <= wr_data;
		end
	end

	// ----------------------------------------------------------
	// read port, read clock
	// ----------------------------------------------------------
	assign rd_slot = ptr.rd_addr[`FIFO_QADDR_WIDTH-1:1];

	// index bit 0 picks upper or lower half
	assign rd_word = ptr.rd_addr[0] ?
		mem[rd_slot][`FIFO_OWORD_WIDTH-1:`FIFO_QWORD_WIDTH] :
		mem[rd_slot][`FIFO_QWORD_WIDTH-1:0];

	always_ff @(posedge reset) begin
		if (ptr.rd_fire) begin
			rd_data <= rd_word;
		end
	end

	// valid pulses one cycle after the strobe
	always_ff @(posedge reset or posedge rdclock) begin
		if (rdclock) begin
			rd_valid <= 1'b0;
		end else begin
			rd_valid <= ptr.rd_fire;
		end
	end

endmodule

/* src/width_conv_fifo.sv */
// width converting dual clock fifo
`timescale 1ns/100ps

module width_conv_fifo (
	// clocks and reset
	input logic wrclk,
	input logic reset,
	input logic rdclock,

	// write side, one oword per strobe
	input logic wr_req,
	input fifo_pkg::oword_t wr_data,

	// read side, one qword per strobe
	input logic rd_req,
	output fifo_pkg::qword_t rd_data,
	output logic rd_valid,

	// write side levels
	output fifo_pkg::qcount_t wr_used,
	output logic full,
	output logic almost_full,

	// read side levels
	output fifo_pkg::qcount_t rd_used,
	output logic empty,
	output logic almost_empty
);

	// strobes and addresses from counters to storage
	fifo_ptr_if u_ptr ();

	usedw_calc u_usedw_calc (
		.wrclk(wrclk),
		.reset(reset),
		.rdclock(rdclock),
		.wr_req(wr_req),
		.rd_req(rd_req),
		.ptr(u_ptr.calc),
		.wr_used(wr_used),
		.rd_used(rd_used),
		.full(full),
		.almost_full(almost_full),
		.empty(empty),
		.almost_empty(almost_empty)
	);

	fifo_ram u_fifo_ram (
		.wrclk(wrclk),
		.reset(reset),
		.rdclock(rdclock),
		.ptr(u_ptr.ram),
		.wr_data(wr_data),
		.rd_data(rd_data),
		.rd_valid(rd_valid)
	);

endmodule

/* tests/fifo_checker.sv */
// fifo response checker
`timescale 1ns/100ps
`include "fifo_cfg.svh"

module fifo_checker (
	input logic wrclk,
	input logic reset,
	input logic rdclock,
	input logic wr_req,
	input fifo_pkg::oword_t wr_data,
	input logic rd_req,
	input fifo_pkg::qword_t rd_data,
	input logic rd_valid,
	input fifo_pkg::qcount_t wr_used,
	input logic full,
	input logic almost_full,
	input fifo_pkg::qcount_t rd_used,
	input logic empty,
	input logic almost_empty,
	input logic step_check,
	input logic check_stb,
	input logic [7:0] exp_flags,
	input logic [7:0] exp_wr,
	input logic [7:0] exp_rd,
	output int test_count,
	output int check_count,
	output int error_count
);
	import fifo_pkg::*;

	localparam int DEPTH = `FIFO_QWORD_DEPTH;
	localparam int MARGIN = `FIFO_ALMOST_MARGIN;

	// expected qwords filled on wrclk and drained on the read clock
	qword_t expect_mem [64];
	int push_cnt = 0;
	int pop_cnt = 0;

	// last sampled strobe and count with one set per clock domain
	logic wr_seen = 1'b0;
	logic wr_step = 1'b0;
	qcount_t wr_prev = '0;
	logic rd_seen = 1'b0;
	logic rd_step = 1'b0;
	qcount_t rd_prev = '0;

	// tallies kept apart per domain
	int wr_checks = 0;
	int wr_errors = 0;
	int rd_checks = 0;
	int rd_errors = 0;
	int tests_done = 0;
	int errors_at_test = 0;

	assign test_count = tests_done;
	assign check_count = wr_checks + rd_checks;
	assign error_count = wr_errors + rd_errors;

	function automatic bit differs(input string name, input int got, input int want);
		if (got != want) begin
			$display("Mismatch at %0t: %s expected %0d got %0d", $time, name, want, got);
		end
		return got != want;
	endfunction

	// ----------------------------------------------------------
	// write side
	// ----------------------------------------------------------
	always @(posedge wrclk) begin
		if (!rdclock) begin
			// a sampled write raises wr_used by two on that same edge
			if (wr_seen && wr_step) begin
				wr_checks++;
				if (differs("wr_used", int'(wr_used), int'(wr_prev) + 2)) begin
					wr_errors++;
				end
			end
			wr_seen = wr_req;
			wr_step = step_check;
			wr_prev = wr_used;
			// lower half leaves first
			if (wr_req) begin
				expect_mem[push_cnt[5:0]] = wr_data[63:0];
				push_cnt++;
				expect_mem[push_cnt[5:0]] = wr_data[127:64];
				push_cnt++;
			end
		end
	end

	// ----------------------------------------------------------
	// read side
	// ----------------------------------------------------------
	task automatic match_read();
		qword_t want;
		if (pop_cnt == push_cnt) begin
			$display("rd_valid pulsed at %0t with no qword left to read", $time);
			rd_errors++;
		end else begin
			want = expect_mem[pop_cnt[5:0]];
			pop_cnt++;
			rd_checks++;
			if (rd_data !== want) begin
				$display("Mismatch at %0t: rd_data expected %h got %h", $time, want, rd_data);
				rd_errors++;
			end
		end
	endtask

	// counts and flags once both sides have settled
	task automatic compare_levels();
		int level;
		int want_wr;
		int want_rd;
		logic [3:0] want_f;
		int failed;
		level = push_cnt - pop_cnt;
		want_wr = (exp_wr == 8'hff) ? level : int'(exp_wr);
		want_rd = (exp_rd == 8'hff) ? level : int'(exp_rd);
		// ff means the flags follow from the modelled level
		if (exp_flags == 8'hff) begin
			want_f = {level == DEPTH, level >= DEPTH - MARGIN, level == 0, level <= MARGIN};
		end else begin
			want_f = exp_flags[3:0];
		end
		failed = 0;
		failed += int'(differs("wr_used", int'(wr_used), want_wr));
		failed += int'(differs("rd_used", int'(rd_used), want_rd));
		failed += int'(differs("full", int'(full), int'(want_f[3])));
		failed += int'(differs("almost_full", int'(almost_full), int'(want_f[2])));
		failed += int'(differs("empty", int'(empty), int'(want_f[1])));
		failed += int'(differs("almost_empty", int'(almost_empty), int'(want_f[0])));
		rd_checks += 6;
		rd_errors += failed;
		tests_done++;
		$display("test %0d done at %0t with %0d errors", tests_done, $time,
			wr_errors + rd_errors - errors_at_test);
		errors_at_test = wr_errors + rd_errors;
	endtask

	always @(posedge reset) begin
		if (!rdclock) begin
			// a sampled read drops rd_used by one
			if (rd_seen && rd_step) begin
				rd_checks++;
				if (differs("rd_used", int'(rd_used), int'(rd_prev) - 1)) begin
					rd_errors++;
				end
			end
			rd_seen = rd_req;
			rd_step = step_check;
			rd_prev = rd_used;
			if (rd_valid) begin
				match_read();
			end
			if (check_stb) begin
				compare_levels();
			end
		end
	end

endmodule

/* tests/tb_width_conv_fifo.sv */
// width converting fifo testbench
`timescale 1ns/100ps
`include "fifo_cfg.svh"

module tb_width_conv_fifo;
	import fifo_pkg::*;

	localparam int REC_WORDS = 6;
	localparam int MAX_RECS = 32;
	localparam int WAIT_LIMIT = 2000;
	localparam int SETTLE_CYCLES = 16;
	// one more oword must still fit
	localparam qcount_t ROOM_LEVEL = qcount_t'(`FIFO_QWORD_DEPTH - 2);

	logic wrclk;
	logic reset;
	logic rdclock;
	logic wr_req;
	logic rd_req;
	oword_t wr_data;
	qword_t rd_data;
	logic rd_valid;
	qcount_t wr_used;
	qcount_t rd_used;
	logic full;
	logic almost_full;
	logic empty;
	logic almost_empty;

	// checker control and expected values
	logic step_check;
	logic check_stb;
	logic [7:0] exp_flags;
	logic [7:0] exp_wr;
	logic [7:0] exp_rd;
	int test_count;
	int check_count;
	int error_count;

	// each record holds op, count, flags, wr_used, rd_used and data
	logic [127:0] patterns [REC_WORDS*MAX_RECS];
	int seed;
	bit aborted = 1'b0;

	width_conv_fifo u_width_conv_fifo (
		.wrclk(wrclk),
		.reset(reset),
		.rdclock(rdclock),
		.wr_req(wr_req),
		.wr_data(wr_data),
		.rd_req(rd_req),
		.rd_data(rd_data),
		.rd_valid(rd_valid),
		.wr_used(wr_used),
		.full(full),
		.almost_full(almost_full),
		.rd_used(rd_used),
		.empty(empty),
		.almost_empty(almost_empty)
	);

	fifo_checker u_fifo_checker (
		.wrclk(wrclk),
		.reset(reset),
		.rdclock(rdclock),
		.wr_req(wr_req),
		.wr_data(wr_data),
		.rd_req(rd_req),
		.rd_data(rd_data),
		.rd_valid(rd_valid),
		.wr_used(wr_used),
		.full(full),
		.almost_full(almost_full),
		.rd_used(rd_used),
		.empty(empty),
		.almost_empty(almost_empty),
		.step_check(step_check),
		.check_stb(check_stb),
		.exp_flags(exp_flags),
		.exp_wr(exp_wr),
		.exp_rd(exp_rd),
		.test_count(test_count),
		.check_count(check_count),
		.error_count(error_count)
	);

	// ----------------------------------------------------------
	// read clock at 4 ns and write clock at 6 ns
	// ----------------------------------------------------------
	initial begin
		reset = 1'b0;
		forever #2 reset = ~reset;
	end

	initial begin
		wrclk = 1'b0;
		forever #3 wrclk = ~wrclk;
	end

	task automatic end_run();
		$display("tests %0d, checks %0d, errors %0d", test_count, check_count, error_count);
		if (aborted || error_count != 0 || test_count == 0) begin
			$display("*** TEST FAILED ***");
		end else begin
			$display("*** TEST PASSED ***");
		end
		$finish;
	endtask

	// ----------------------------------------------------------
	// stimulus
	// ----------------------------------------------------------
	// one write held off while the write side shows no room
	task automatic write_oword(input oword_t word);
		int waited;
		waited = 0;
		@(negedge wrclk);
		while (wr_used > ROOM_LEVEL && waited < WAIT_LIMIT) begin
			@(negedge wrclk);
			waited++;
		end
		if (wr_used > ROOM_LEVEL) begin
			$display("no room to write after %0d cycles at %0t", waited, $time);
			aborted = 1'b1;
		end else begin
			@(posedge wrclk);
			wr_req <= 1'b1;
			wr_data <= word;
			@(posedge wrclk);
			wr_req <= 1'b0;
		end
	endtask

	// one read held off until the read side sees data
	task automatic read_qword();
		int waited;
		waited = 0;
		@(negedge reset);
		while (rd_used == '0 && waited < WAIT_LIMIT) begin
			@(negedge reset);
			waited++;
		end
		if (rd_used == '0) begin
			$display("no data to read after %0d cycles at %0t", waited, $time);
			aborted = 1'b1;
		end else begin
			@(posedge reset);
			rd_req <= 1'b1;
			@(posedge reset);
			rd_req <= 1'b0;
		end
	endtask

	// wait for both counts to hold still, then hand expectations over
	task automatic settle(input logic [7:0] flags, input logic [7:0] want_wr,
		input logic [7:0] want_rd);
		int stable;
		int waited;
		qcount_t last_wr;
		qcount_t last_rd;
		stable = 0;
		waited = 0;
		@(negedge reset);
		last_wr = wr_used;
		last_rd = rd_used;
		while (stable < SETTLE_CYCLES && waited < WAIT_LIMIT) begin
			@(negedge reset);
			waited++;
			if (wr_used == last_wr && rd_used == last_rd) begin
				stable++;
			end else begin
				stable = 0;
				last_wr = wr_used;
				last_rd = rd_used;
			end
		end
		if (stable < SETTLE_CYCLES) begin
			$display("counts never settled, wr_used %0d rd_used %0d at %0t",
				wr_used, rd_used, $time);
			aborted = 1'b1;
		end else begin
			@(posedge reset);
			check_stb <= 1'b1;
			exp_flags <= flags;
			exp_wr <= want_wr;
			exp_rd <= want_rd;
			@(posedge reset);
			check_stb <= 1'b0;
		end
	endtask

	// counts lag the real level so a random mix that obeys them stays legal
	task automatic random_mix(input int steps);
		int r;
		for (int i = 0; i < steps && !aborted; i++) begin
			@(negedge reset);
			r = $random(seed);
			if (r[0] && wr_used <= ROOM_LEVEL) begin
				write_oword({$random(seed), $random(seed), $random(seed), $random(seed)});
			end else if (rd_used != '0) begin
				read_qword();
			end else if (wr_used <= ROOM_LEVEL) begin
				write_oword({$random(seed), $random(seed), $random(seed), $random(seed)});
			end
		end
	endtask

	initial begin
		int rec;
		int cnt;
		logic [3:0] op;
		oword_t base;
		rdclock = 1'b1;
		wr_req = 1'b0;
		rd_req = 1'b0;
		wr_data = '0;
		step_check = 1'b0;
		check_stb = 1'b0;
		exp_flags = '0;
		exp_wr = '0;
		exp_rd = '0;
		seed = 32'h9d950fea;
		$readmemh("tests/fifo_patterns.txt", patterns);
		repeat (5) @(posedge reset);
		rdclock <= 1'b0;
		rec = 0;
		while (rec < MAX_RECS && !aborted) begin
			op = patterns[rec*REC_WORDS][3:0];
			cnt = patterns[rec*REC_WORDS+1][31:0];
			base = patterns[rec*REC_WORDS+5];
			if (op == 4'h0) begin
				break;
			end
			case (op)
				4'h1: begin
					step_check <= 1'b1;
					// both halves differ per write
					for (int i = 0; i < cnt && !aborted; i++) begin
						write_oword(base + (oword_t'(i) << 64) + oword_t'(i));
					end
					step_check <= 1'b0;
				end
				4'h2: begin
					step_check <= 1'b1;
					for (int i = 0; i < cnt && !aborted; i++) begin
						read_qword();
					end
					step_check <= 1'b0;
				end
				4'h3: settle(patterns[rec*REC_WORDS+2][7:0], patterns[rec*REC_WORDS+3][7:0],
					patterns[rec*REC_WORDS+4][7:0]);
				4'h4: random_mix(cnt);
				default: begin
					$display("unknown operation %0h in pattern record %0d", op, rec);
					aborted = 1'b1;
				end
			endcase
			rec++;
		end
		repeat (2) @(posedge reset);
		end_run();
	end

	// overall limit on the run
	initial begin
		#200000;
		$display("run exceeded its time limit of 200 us");
		aborted = 1'b1;
		end_run();
	end

endmodule

/* width_conv_fifo.f */
+incdir+src
src/fifo_pkg.sv
src/fifo_ptr_if.sv
src/gray_sync.sv
src/delay_line.sv
src/usedw_calc.sv
src/fifo_ram.sv
src/width_conv_fifo.sv
tests/fifo_checker.sv
tests/tb_width_conv_fifo.sv

/* Makefile */
# Verilator flow for the width converting FIFO

TOP = tb_width_conv_fifo

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --timescale 1ns/100ps \
		-f width_conv_fifo.f --top-module $(TOP)

sim:
	verilator --binary --timing --timescale 1ns/100ps -j 0 \
		-f width_conv_fifo.f --top-module $(TOP)
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF '*** TEST PASSED ***'

clean:
	rm -rf obj_dir

/* tests/fifo_patterns.txt */
// op count flags wr_used rd_used data; op 1 write, 2 read, 3 settle, 4 random, 0 end
// flags are {full almost_full empty almost_empty}; ff takes the value from the model
3 0 3 00 00 0
1 2 0 00 00 0123456789abcdeffedcba9876543210
3 0 1 04 04 0
2 4 0 00 00 0
3 0 3 00 00 0
1 3 0 00 00 00112233445566778899aabbccddeeff
3 0 1 06 06 0
2 5 0 00 00 0
3 0 1 01 01 0
2 1 0 00 00 0
3 0 3 00 00 0
1 10 0 00 00 f0e1d2c3b4a5968778695a4b3c2d1e0f
3 0 c 20 20 0
2 16 0 00 00 0
3 0 1 0a 0a 0
2 a 0 00 00 0
3 0 3 00 00 0
4 c8 0 00 00 0
3 0 ff ff ff 0
0 0 0 00 00 0
